// ==== src/accel_geom_pkg.sv ====
package accel_geom_pkg;

    //////////////////////////////////////////////////////////////////////
    // Row buffer and engine geometry
    //////////////////////////////////////////////////////////////////////

    localparam int ROW_BUF_DEPTH  = 1024;
    localparam int ROW_IDX_W      = $clog2(ROW_BUF_DEPTH);

    // Four AWEs with two CEs each
    localparam int NUM_AWE        = 4;
    localparam int NUM_CE_PER_AWE = 2;
    localparam int NUM_CE         = NUM_AWE * NUM_CE_PER_AWE;

    localparam int KERNEL_IDX_W   = 4;
    localparam int PFB_COUNT_W    = 10;
    localparam int SEQ_ADDR_W     = 12;

    // 3x3 window, one tap per cycle
    localparam int WINDOW_CYCLES  = 9;
    localparam int CYCLE_CNT_W    = $clog2(WINDOW_CYCLES);

    // Rows held before the first pass
    localparam int PRIME_ROWS       = 4;
    localparam int SEQ_READ_LATENCY = 3;

endpackage

// ==== src/quad_ctrl_pkg.sv ====
package quad_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Control state and sequencing
    //////////////////////////////////////////////////////////////////////

    localparam int STATE_W      = 6;

    // Two-bit row phase behind the Gray output
    localparam int PHASE_W      = 2;

    // Extra read-enable cycles so the BRAM pipeline empties
    localparam int RDEN_STRETCH = 2;

    typedef enum logic [STATE_W-1:0] {
        ST_IDLE          = 6'b000001,
        ST_PRIME_BUFFER  = 6'b000010,
        ST_WAIT_PFB_LOAD = 6'b000100,
        ST_ACTIVE        = 6'b001000,
        ST_WAIT_JOB_DONE = 6'b010000,
        ST_SEND_COMPLETE = 6'b100000
    } ctrl_state_t;

endpackage

// ==== src/pfb_if.sv ====
`timescale 1ns/1ps

interface pfb_if;

    // Sequencer side
    logic load;
    logic read_run;

    // Tracker side
    logic empty;
    logic full;
    logic rows_done;

    modport seq (
        output load,
        output read_run,
        input  empty,
        input  full,
        input  rows_done
    );

    modport tracker (
        input  load,
        input  read_run,
        output empty,
        output full,
        output rows_done
    );

endinterface

// ==== src/job_sequencer.sv ====
`timescale 1ns/1ps

module job_sequencer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   job_start,
    input  logic                                   job_fetch_ack,
    input  logic                                   job_fetch_complete,
    input  logic                                   job_complete_ack,
    input  logic                                   pipeline_flushed,
    input  logic                                   pass_drained,
    input  logic [accel_geom_pkg::ROW_IDX_W-1:0]   input_row,
    input  logic [accel_geom_pkg::PFB_COUNT_W-1:0] pfb_count,
    pfb_if.seq                                     pfb,
    output logic                                   job_accept,
    output logic                                   job_fetch_request,
    output logic                                   job_fetch_in_progress,
    output logic                                   job_complete,
    output quad_ctrl_pkg::ctrl_state_t             state,
    output logic                                   pass_start,
    output logic                                   job_end
);
    import accel_geom_pkg::*;
    import quad_ctrl_pkg::*;

    ctrl_state_t return_state;
    logic        fetch_acked;
    logic        fetch_taken;

    assign fetch_taken  = job_fetch_request && job_fetch_ack;
    assign pfb.load     = job_fetch_complete && job_fetch_in_progress;
    assign pfb.read_run = (state == ST_PRIME_BUFFER) || (state == ST_ACTIVE);

    always_ff @(posedge clk) begin
        if (rst) begin
            job_fetch_in_progress <= 1'b0;
        end else if (fetch_taken) begin
            job_fetch_in_progress <= 1'b1;
        end else if (job_fetch_complete) begin
            job_fetch_in_progress <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Job FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= ST_IDLE;
            return_state      <= ST_PRIME_BUFFER;
            fetch_acked       <= 1'b0;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            pass_start        <= 1'b0;
            job_end           <= 1'b0;
        end else begin
            job_accept <= 1'b0;
            pass_start <= 1'b0;
            job_end    <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= ST_PRIME_BUFFER;
                    end
                end
                ST_PRIME_BUFFER: begin
                    if (input_row == ROW_IDX_W'(PRIME_ROWS - 1) && pfb.full) begin
                        pass_start <= 1'b1;
                        state      <= ST_ACTIVE;
                    end else if (pfb.empty) begin
                        return_state <= ST_PRIME_BUFFER;
                        state        <= ST_WAIT_PFB_LOAD;
                    end
                end
                ST_WAIT_PFB_LOAD: begin
                    // Request held until the ack is seen, once per visit
                    if (fetch_taken) begin
                        job_fetch_request <= 1'b0;
                        fetch_acked       <= 1'b1;
                    end else if (!fetch_acked) begin
                        job_fetch_request <= 1'b1;
                    end
                    if (pfb.load) begin
                        fetch_acked <= 1'b0;
                        state       <= return_state;
                        pass_start  <= (return_state == ST_ACTIVE);
                    end
                end
                ST_ACTIVE: begin
                    if (pass_drained) begin
                        if (pfb.rows_done) begin
                            state <= ST_WAIT_JOB_DONE;
                        end else if (pfb.empty) begin
                            return_state <= ST_ACTIVE;
                            state        <= ST_WAIT_PFB_LOAD;
                        end else begin
                            pass_start <= 1'b1;
                        end
                    end
                end
                ST_WAIT_JOB_DONE: begin
                    if (pipeline_flushed) begin
                        job_complete <= 1'b1;
                        state        <= ST_SEND_COMPLETE;
                    end
                end
                ST_SEND_COMPLETE: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        job_end      <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // A new fetch only starts on a drained PFB with no fetch outstanding
    a_fetch_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(job_fetch_request) |-> (!job_fetch_in_progress && pfb_count == '0));

    a_state_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot(state));

endmodule

// ==== src/input_window_tracker.sv ====
`timescale 1ns/1ps

module input_window_tracker (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [accel_geom_pkg::ROW_IDX_W-1:0]   num_expd_input_cols,
    input  logic [accel_geom_pkg::ROW_IDX_W-1:0]   num_expd_input_rows,
    input  logic [accel_geom_pkg::PFB_COUNT_W-1:0] pfb_full_count,
    input  logic                                   job_complete_ack,
    pfb_if.tracker                                 pfb,
    output logic                                   pfb_rden,
    output logic [accel_geom_pkg::ROW_IDX_W-1:0]   input_row,
    output logic [accel_geom_pkg::ROW_IDX_W-1:0]   input_col,
    output logic [accel_geom_pkg::PFB_COUNT_W-1:0] pfb_count
);
    import accel_geom_pkg::*;

    assign pfb.empty     = (pfb_count == '0);
    assign pfb.full      = (pfb_count == pfb_full_count);
    assign pfb.rows_done = (input_row > num_expd_input_rows);

    // One read already in flight counts against the occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_rden <= 1'b0;
        end else begin
            pfb_rden <= pfb.read_run && (pfb_count > PFB_COUNT_W'(pfb_rden));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_count <= '0;
        end else if (job_complete_ack) begin
            pfb_count <= '0;
        end else if (pfb.load) begin
            pfb_count <= pfb_full_count;
        end else if (pfb_rden) begin
            pfb_count <= pfb_count - 1'b1;
        end
    end

    // Column wraps on the read that lands on the last expanded column
    always_ff @(posedge clk) begin
        if (rst) begin
            input_row <= '0;
            input_col <= '0;
        end else if (job_complete_ack) begin
            input_row <= '0;
            input_col <= '0;
        end else if (pfb_rden) begin
            if (input_col == num_expd_input_cols) begin
                input_col <= '0;
                input_row <= input_row + 1'b1;
            end else begin
                input_col <= input_col + 1'b1;
            end
        end
    end

    a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> (pfb_count != '0));

endmodule

// ==== src/pix_seq_reader.sv ====
`timescale 1ns/1ps

module pix_seq_reader (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    pass_start,
    input  logic                                    job_end,
    input  logic                                    pass_drained,
    input  logic [accel_geom_pkg::SEQ_ADDR_W-1:0]   pix_seq_data_full_count,
    output logic                                    seq_rden_req,
    output logic                                    pix_seq_bram_rden,
    output logic [accel_geom_pkg::SEQ_ADDR_W-1:0]   pix_seq_bram_rd_addr,
    output logic [accel_geom_pkg::CYCLE_CNT_W-1:0]  cycle_counter,
    output logic                                    window_end,
    output logic [quad_ctrl_pkg::PHASE_W-1:0]       gray_code
);
    import accel_geom_pkg::*;
    import quad_ctrl_pkg::*;

    logic [SEQ_ADDR_W-1:0]   remaining;
    logic [RDEN_STRETCH-1:0] req_d;
    logic [PHASE_W-1:0]      phase;

    assign seq_rden_req      = (remaining != '0);
    assign window_end        = seq_rden_req &&
                               (cycle_counter == CYCLE_CNT_W'(WINDOW_CYCLES - 1));
    assign pix_seq_bram_rden = seq_rden_req || (|req_d);
    assign gray_code         = phase ^ (phase >> 1);

    //////////////////////////////////////////////////////////////////////
    // Sequence address, one full sweep per pass
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining            <= '0;
            pix_seq_bram_rd_addr <= '0;
        end else if (pass_start) begin
            remaining            <= pix_seq_data_full_count;
            pix_seq_bram_rd_addr <= '0;
        end else if (seq_rden_req) begin
            remaining            <= remaining - 1'b1;
            pix_seq_bram_rd_addr <= pix_seq_bram_rd_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_d <= '0;
        end else begin
            req_d[0] <= seq_rden_req;
            for (int i = 1; i < RDEN_STRETCH; i++) begin
                req_d[i] <= req_d[i-1];
            end
        end
    end

    // Window tap index
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_counter <= '0;
        end else if (pass_start) begin
            cycle_counter <= '0;
        end else if (seq_rden_req) begin
            cycle_counter <= window_end ? '0 : cycle_counter + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else if (job_end) begin
            phase <= '0;
        end else if (pass_drained) begin
            phase <= phase + 1'b1;
        end
    end

    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        seq_rden_req |-> (pix_seq_bram_rd_addr < pix_seq_data_full_count));

endmodule

// ==== src/ce_dispatch.sv ====
`timescale 1ns/1ps

module ce_dispatch (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    seq_rden_req,
    input  logic                                    window_end,
    input  logic [accel_geom_pkg::ROW_IDX_W-1:0]    num_output_cols,
    input  logic [accel_geom_pkg::KERNEL_IDX_W-1:0] num_kernels,
    output logic [accel_geom_pkg::NUM_CE-1:0]       ce_execute,
    output logic [accel_geom_pkg::NUM_CE-1:0]       next_kernel,
    output logic                                    ctrl_last_kernel,
    output logic                                    pass_drained
);
    import accel_geom_pkg::*;

    logic [SEQ_READ_LATENCY-2:0] lat_q;
    logic [ROW_IDX_W-1:0]        output_col;
    logic [KERNEL_IDX_W-1:0]     kernel_group;
    logic                        exec_busy;
    logic                        last_col;

    assign last_col         = (output_col == num_output_cols - 1'b1);
    assign ctrl_last_kernel = (kernel_group == num_kernels);
    assign pass_drained     = exec_busy && !(|ce_execute);

    //////////////////////////////////////////////////////////////////////
    // Execute and next-kernel chains, one CE further per cycle
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            lat_q       <= '0;
            ce_execute  <= '0;
            next_kernel <= '0;
            exec_busy   <= 1'b0;
        end else begin
            // Covers the sequence BRAM read latency
            lat_q[0] <= seq_rden_req;
            for (int i = 1; i < SEQ_READ_LATENCY - 1; i++) begin
                lat_q[i] <= lat_q[i-1];
            end
            ce_execute  <= {ce_execute[NUM_CE-2:0], lat_q[SEQ_READ_LATENCY-2]};
            next_kernel <= {next_kernel[NUM_CE-2:0], window_end && last_col};
            exec_busy   <= |ce_execute;
        end
    end

    // Output column, realigned at each pass
    always_ff @(posedge clk) begin
        if (rst) begin
            output_col <= '0;
        end else if (pass_drained) begin
            output_col <= '0;
        end else if (window_end) begin
            output_col <= last_col ? '0 : output_col + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_group <= '0;
        end else if (window_end) begin
            kernel_group <= ctrl_last_kernel ? '0 : kernel_group + 1'b1;
        end
    end

endmodule

// ==== src/quad_ctrl_top.sv ====
`timescale 1ns/1ps

module quad_ctrl_top (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [accel_geom_pkg::ROW_IDX_W-1:0]    num_expd_input_cols,
    input  logic [accel_geom_pkg::ROW_IDX_W-1:0]    num_expd_input_rows,
    input  logic [accel_geom_pkg::ROW_IDX_W-1:0]    num_output_cols,
    input  logic                                    job_start,
    input  logic                                    job_fetch_ack,
    input  logic                                    job_fetch_complete,
    input  logic [accel_geom_pkg::PFB_COUNT_W-1:0]  pfb_full_count,
    input  logic [accel_geom_pkg::SEQ_ADDR_W-1:0]   pix_seq_data_full_count,
    input  logic [accel_geom_pkg::KERNEL_IDX_W-1:0] num_kernels,
    input  logic                                    job_complete_ack,
    input  logic                                    pipeline_flushed,
    output logic                                    job_accept,
    output logic                                    job_fetch_request,
    output logic                                    job_fetch_in_progress,
    output logic                                    job_complete,
    output quad_ctrl_pkg::ctrl_state_t              state,
    output logic [accel_geom_pkg::ROW_IDX_W-1:0]    input_row,
    output logic [accel_geom_pkg::ROW_IDX_W-1:0]    input_col,
    output logic                                    pfb_rden,
    output logic                                    pix_seq_bram_rden,
    output logic [accel_geom_pkg::SEQ_ADDR_W-1:0]   pix_seq_bram_rd_addr,
    output logic [accel_geom_pkg::CYCLE_CNT_W-1:0]  cycle_counter,
    output logic [quad_ctrl_pkg::PHASE_W-1:0]       gray_code,
    output logic [accel_geom_pkg::NUM_CE-1:0]       ce_execute,
    output logic [accel_geom_pkg::NUM_CE-1:0]       next_kernel,
    output logic                                    ctrl_last_kernel
);
    import accel_geom_pkg::*;

    logic                   pass_start;
    logic                   pass_drained;
    logic                   seq_rden_req;
    logic                   window_end;
    logic                   job_end;
    logic [PFB_COUNT_W-1:0] pfb_count;

    pfb_if pfb_bus ();

    job_sequencer job_sequencer_inst (
        .clk                   (clk),
        .rst                   (rst),
        .job_start             (job_start),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_complete_ack      (job_complete_ack),
        .pipeline_flushed      (pipeline_flushed),
        .pass_drained          (pass_drained),
        .input_row             (input_row),
        .pfb_count             (pfb_count),
        .pfb                   (pfb_bus.seq),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .job_complete          (job_complete),
        .state                 (state),
        .pass_start            (pass_start),
        .job_end               (job_end)
    );

    input_window_tracker input_window_tracker_inst (
        .clk                 (clk),
        .rst                 (rst),
        .num_expd_input_cols (num_expd_input_cols),
        .num_expd_input_rows (num_expd_input_rows),
        .pfb_full_count      (pfb_full_count),
        .job_complete_ack    (job_complete_ack),
        .pfb                 (pfb_bus.tracker),
        .pfb_rden            (pfb_rden),
        .input_row           (input_row),
        .input_col           (input_col),
        .pfb_count           (pfb_count)
    );

    pix_seq_reader pix_seq_reader_inst (
        .clk                     (clk),
        .rst                     (rst),
        .pass_start              (pass_start),
        .job_end                 (job_end),
        .pass_drained            (pass_drained),
        .pix_seq_data_full_count (pix_seq_data_full_count),
        .seq_rden_req            (seq_rden_req),
        .pix_seq_bram_rden       (pix_seq_bram_rden),
        .pix_seq_bram_rd_addr    (pix_seq_bram_rd_addr),
        .cycle_counter           (cycle_counter),
        .window_end              (window_end),
        .gray_code               (gray_code)
    );

    ce_dispatch ce_dispatch_inst (
        .clk              (clk),
        .rst              (rst),
        .seq_rden_req     (seq_rden_req),
        .window_end       (window_end),
        .num_output_cols  (num_output_cols),
        .num_kernels      (num_kernels),
        .ce_execute       (ce_execute),
        .next_kernel      (next_kernel),
        .ctrl_last_kernel (ctrl_last_kernel),
        .pass_drained     (pass_drained)
    );

endmodule

// ==== tests/tb_quad_ctrl.sv ====
`timescale 1ns/1ps

module tb_quad_ctrl;
    import accel_geom_pkg::*;
    import quad_ctrl_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int DRIVE_DELAY    = 2;
    localparam int NUM_JOBS       = 20;
    localparam int CYCLES_PER_JOB = 4000;

    logic                    clk = 1'b0;
    logic                    rst;
    logic [ROW_IDX_W-1:0]    num_expd_input_cols;
    logic [ROW_IDX_W-1:0]    num_expd_input_rows;
    logic [ROW_IDX_W-1:0]    num_output_cols;
    logic                    job_start;
    logic                    job_fetch_ack;
    logic                    job_fetch_complete;
    logic [PFB_COUNT_W-1:0]  pfb_full_count;
    logic [SEQ_ADDR_W-1:0]   pix_seq_data_full_count;
    logic [KERNEL_IDX_W-1:0] num_kernels;
    logic                    job_complete_ack;
    logic                    pipeline_flushed;
    logic                    job_accept;
    logic                    job_fetch_request;
    logic                    job_fetch_in_progress;
    logic                    job_complete;
    ctrl_state_t             state;
    logic [ROW_IDX_W-1:0]    input_row;
    logic [ROW_IDX_W-1:0]    input_col;
    logic                    pfb_rden;
    logic                    pix_seq_bram_rden;
    logic [SEQ_ADDR_W-1:0]   pix_seq_bram_rd_addr;
    logic [CYCLE_CNT_W-1:0]  cycle_counter;
    logic [PHASE_W-1:0]      gray_code;
    logic [NUM_CE-1:0]       ce_execute;
    logic [NUM_CE-1:0]       next_kernel;
    logic                    ctrl_last_kernel;

    // Reference model state
    int                      remaining;
    int                      exp_addr;
    int                      win_cnt;
    int                      out_col;
    int                      accept_count;
    int                      read_count;
    int                      load_sum;
    int                      error_count;
    logic [15:0]             req_hist;
    logic                    req_m;
    logic                    win_end_m;
    logic                    fip_m;
    logic [NUM_CE-1:0]       exp_exec;
    logic [NUM_CE-1:0]       exp_nk;
    logic [NUM_CE-1:0]       exec_q;
    logic [KERNEL_IDX_W-1:0] kg_m;
    logic [PHASE_W-1:0]      phase_m;
    logic                    start_q;
    logic                    req_q;
    logic                    fack_q;
    logic                    fcpl_q;
    logic                    cpl_q;
    logic                    cack_q;
    logic                    bram_rden_q;
    logic                    rst_q;
    ctrl_state_t             state_q;

    quad_ctrl_top quad_ctrl_top_inst (
        .clk                     (clk),
        .rst                     (rst),
        .num_expd_input_cols     (num_expd_input_cols),
        .num_expd_input_rows     (num_expd_input_rows),
        .num_output_cols         (num_output_cols),
        .job_start               (job_start),
        .job_fetch_ack           (job_fetch_ack),
        .job_fetch_complete      (job_fetch_complete),
        .pfb_full_count          (pfb_full_count),
        .pix_seq_data_full_count (pix_seq_data_full_count),
        .num_kernels             (num_kernels),
        .job_complete_ack        (job_complete_ack),
        .pipeline_flushed        (pipeline_flushed),
        .job_accept              (job_accept),
        .job_fetch_request       (job_fetch_request),
        .job_fetch_in_progress   (job_fetch_in_progress),
        .job_complete            (job_complete),
        .state                   (state),
        .input_row               (input_row),
        .input_col               (input_col),
        .pfb_rden                (pfb_rden),
        .pix_seq_bram_rden       (pix_seq_bram_rden),
        .pix_seq_bram_rd_addr    (pix_seq_bram_rd_addr),
        .cycle_counter           (cycle_counter),
        .gray_code               (gray_code),
        .ce_execute              (ce_execute),
        .next_kernel             (next_kernel),
        .ctrl_last_kernel        (ctrl_last_kernel)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "Simulation stopped at the first mismatch");
        end
    endtask

    // Inputs change a short delay after the rising edge
    task automatic after_edges(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    function automatic logic [1:0] gray_of(input logic [1:0] p);
        case (p)
            2'd0:    return 2'd0;
            2'd1:    return 2'd1;
            2'd2:    return 2'd3;
            default: return 2'd2;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Job driver
    //////////////////////////////////////////////////////////////////////

    task automatic run_job(input int job);
        int cols;
        cols                    = $urandom_range(3, 6);
        num_expd_input_cols     = cols;
        num_expd_input_rows     = $urandom_range(4, 6);
        num_output_cols         = cols - 2;
        pfb_full_count          = cols + 1;
        pix_seq_data_full_count = $urandom_range(9, 27);
        num_kernels             = $urandom_range(0, 3);
        accept_count            = 0;
        read_count              = 0;
        load_sum                = 0;
        job_start = 1'b1;
        after_edges(1);
        job_start = 1'b0;
        while (state != ST_WAIT_JOB_DONE) begin
            after_edges(1);
        end
        after_edges($urandom_range(0, 5));
        pipeline_flushed = 1'b1;
        after_edges(1);
        pipeline_flushed = 1'b0;
        after_edges($urandom_range(0, 5));
        job_complete_ack = 1'b1;
        after_edges(1);
        job_complete_ack = 1'b0;
        check_eq(state, ST_IDLE, $sformatf("job %0d state after complete ack", job));
        check_eq(input_row, 0, $sformatf("job %0d input_row after complete ack", job));
        after_edges(1);
        check_eq(accept_count, 1, $sformatf("job %0d job_accept pulses", job));
        check_eq(read_count, load_sum, $sformatf("job %0d pfb_rden pulses", job));
    endtask

    initial begin
        void'($urandom(81));
        error_count             = 0;
        rst                     = 1'b1;
        job_start               = 1'b0;
        job_fetch_ack           = 1'b0;
        job_fetch_complete      = 1'b0;
        job_complete_ack        = 1'b0;
        pipeline_flushed        = 1'b0;
        num_expd_input_cols     = 4;
        num_expd_input_rows     = 4;
        num_output_cols         = 2;
        pfb_full_count          = 5;
        pix_seq_data_full_count = 9;
        num_kernels             = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        for (int job = 0; job < NUM_JOBS; job++) begin
            run_job(job);
        end
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // PFB fetch responder
    initial begin : fetch_responder
        int d;
        @(negedge rst);
        forever begin
            after_edges(1);
            if (job_fetch_request) begin
                after_edges($urandom_range(0, 5));
                job_fetch_ack = 1'b1;
                after_edges(1);
                job_fetch_ack = 1'b0;
                d = $urandom_range(1, 4);
                after_edges(d - 1);
                job_fetch_complete = 1'b1;
                after_edges(1);
                job_fetch_complete = 1'b0;
            end
        end
    end

    initial begin
        #((RESET_CYCLES + NUM_JOBS * CYCLES_PER_JOB) * CLK_PERIOD);
        $display("Watchdog expired: the jobs did not finish in time, the DUT seems hung");
        $display("** FAIL **");
        $fatal(1, "Watchdog timeout");
    end

    //////////////////////////////////////////////////////////////////////
    // Monitor and model, sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst || rst_q) begin
            check_eq({job_accept, job_fetch_request, job_fetch_in_progress, job_complete,
                      pfb_rden, pix_seq_bram_rden, ce_execute, next_kernel}, 0,
                     "control outputs around reset");
            check_eq(state, ST_IDLE, "state around reset");
        end
        if (rst) begin
            remaining = 0;
            exp_addr  = 0;
            win_cnt   = 0;
            out_col   = 0;
            req_hist  = '0;
            exec_q    = '0;
            exp_nk    = '0;
            fip_m     = 1'b0;
            kg_m      = '0;
            phase_m   = '0;
        end else begin
            // Handshakes
            check_eq(job_accept, start_q, "job_accept pulse");
            if (req_q) begin
                check_eq(job_fetch_request, !fack_q, "job_fetch_request hold until ack");
            end
            if (cpl_q) begin
                check_eq(job_complete, !cack_q, "job_complete hold until ack");
            end
            // In progress from the cycle after ack to the cycle after complete
            if (req_q && fack_q) begin
                fip_m = 1'b1;
            end else if (fcpl_q) begin
                fip_m = 1'b0;
            end
            check_eq(job_fetch_in_progress, fip_m, "job_fetch_in_progress");
            accept_count += job_accept;
            read_count   += pfb_rden;
            if (job_fetch_complete && fip_m) begin
                load_sum += pfb_full_count;
            end
            check_eq(input_col <= num_expd_input_cols, 1, "input_col range");

            // A new pass shows as a rising read enable
            if (remaining == 0 && pix_seq_bram_rden && !bram_rden_q) begin
                remaining = pix_seq_data_full_count;
                exp_addr  = 0;
                win_cnt   = 0;
            end
            req_m = (remaining != 0);
            check_eq(pix_seq_bram_rden, req_m || req_hist[0] || req_hist[1],
                     "pix_seq_bram_rden stretch");
            for (int i = 0; i < NUM_CE; i++) begin
                exp_exec[i] = req_hist[SEQ_READ_LATENCY - 1 + i];
            end
            check_eq(ce_execute, exp_exec, "ce_execute chain");
            check_eq(next_kernel, exp_nk, "next_kernel chain");
            check_eq(ctrl_last_kernel, kg_m == num_kernels, "ctrl_last_kernel");
            check_eq(gray_code, gray_of(phase_m), "gray_code");

            // Next-kernel pulse follows the last window of an output row
            win_end_m = req_m && (win_cnt == WINDOW_CYCLES - 1);
            exp_nk    = {exp_nk[NUM_CE-2:0],
                         win_end_m && (out_col == num_output_cols - 1)};
            if (req_m) begin
                check_eq(pix_seq_bram_rd_addr, exp_addr, "pix_seq_bram_rd_addr");
                check_eq(cycle_counter, win_cnt, "cycle_counter");
                if (win_cnt == WINDOW_CYCLES - 1) begin
                    win_cnt = 0;
                    kg_m    = (kg_m == num_kernels) ? '0 : kg_m + 1'b1;
                end else begin
                    win_cnt++;
                end
                exp_addr++;
                remaining--;
            end

            // Pass drain and job end move the row phase
            if (exp_exec == '0 && exec_q != '0) begin
                phase_m = phase_m + 1'b1;
                out_col = 0;
            end else if (win_end_m) begin
                out_col = (out_col == num_output_cols - 1) ? 0 : out_col + 1;
            end
            if (state_q == ST_SEND_COMPLETE && state == ST_IDLE) begin
                phase_m = '0;
            end
            req_hist = {req_hist[14:0], req_m};
            exec_q   = exp_exec;
        end
        start_q     = job_start && (state == ST_IDLE);
        req_q       = job_fetch_request;
        fack_q      = job_fetch_ack;
        fcpl_q      = job_fetch_complete;
        cpl_q       = job_complete;
        cack_q      = job_complete_ack;
        bram_rden_q = pix_seq_bram_rden;
        state_q     = state;
        rst_q       = rst;
    end

endmodule

// ==== build.f ====
src/accel_geom_pkg.sv
src/quad_ctrl_pkg.sv
src/pfb_if.sv
src/job_sequencer.sv
src/input_window_tracker.sv
src/pix_seq_reader.sv
src/ce_dispatch.sv
src/quad_ctrl_top.sv
tests/tb_quad_ctrl.sv

// ==== Bender.yml ====
package:
  name: quad_ctrl

sources:
  - src/accel_geom_pkg.sv
  - src/quad_ctrl_pkg.sv
  - src/pfb_if.sv
  - src/job_sequencer.sv
  - src/input_window_tracker.sv
  - src/pix_seq_reader.sv
  - src/ce_dispatch.sv
  - src/quad_ctrl_top.sv
  - target: test
    files:
      - tests/tb_quad_ctrl.sv
